// ==== sif_monitor.f ====
design/sif_mon_pkg.sv
design/sif_cmd_decode.sv
design/sif_clkgate_window.sv
design/sif_event_counter.sv
design/sif_monitor_top.sv
testbench/tb_sif_monitor.sv

// ==== Bender.yml ====
package:
  name: sif_monitor

sources:
  - files:
      - design/sif_mon_pkg.sv
      - design/sif_cmd_decode.sv
      - design/sif_clkgate_window.sv
      - design/sif_event_counter.sv
      - design/sif_monitor_top.sv
  - target: test
    files:
      - testbench/tb_sif_monitor.sv

// ==== testbench/tb_sif_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_sif_monitor
    import sif_mon_pkg::*;
;

    localparam int unsigned TB_CNT_W = 6;
    localparam int unsigned CNT_MAX = (1 << TB_CNT_W) - 1;
    localparam int unsigned WIN_CYC = 32;
    localparam int unsigned TEST_CYC = 3 + 65 + 60 + (5 * WIN_CYC + 10) + (WIN_CYC + 20)
                                     + (18 * WIN_CYC + 10);
    localparam int unsigned WATCHDOG_CYC = TEST_CYC + 200;

    logic       hqm_sif_core;
    logic       rst_n;
    logic       cmd_put;
    sif_cmd_t   cmd;
    logic       func_in_rst;
    logic       clk_enable_sys;
    logic       stats_clr;
    logic       gate_hazard;
    sif_stats_t stats;

    logic [31:0] lfsr_state;
    int          error_count;
    int          test_errors;
    int          pass_count;
    int          fail_count;

    sif_monitor_top #(.CNT_WIDTH(TB_CNT_W)) i_sif_monitor_top (
        .hqm_sif_core     (hqm_sif_core),
        .i_rst_n          (rst_n),
        .i_cmd_put        (cmd_put),
        .i_cmd            (cmd),
        .i_func_in_rst    (func_in_rst),
        .i_clk_enable_sys (clk_enable_sys),
        .i_stats_clr      (stats_clr),
        .o_gate_hazard    (gate_hazard),
        .o_stats          (stats)
    );

    initial begin
        hqm_sif_core = 1'b0;
        forever begin
            #50 hqm_sif_core = ~hqm_sif_core;
        end
    end

    // reference model with every history aligned to the input cycle.
    logic [WIN_LEN-1:0] m_en_h, m_p_h, m_np_h, m_cpl_h;
    logic [WIN_LEN-1:0] en_now, p_now, np_now, cpl_now;
    logic               m_mal, m_flr, m_acc, m_poi, m_match;
    logic               m_drop_s1, m_haz_s1, m_flr_s1, m_poi_s1, m_mal_s1;
    logic               m_drop_s2, m_haz_s2;
    int unsigned        m_wp_s1, m_wnp_s1, m_wcpl_s1, m_wp_s2, m_wnp_s2, m_wcpl_s2;
    logic [CNT_W-1:0]   m_hz_p, m_hz_np, m_hz_cpl, m_drops, m_flr_cnt, m_poi_cnt, m_mal_cnt;

    always_comb begin
        m_mal = cmd_put && ((cmd.rtype == RTYPE_RSVD) ||
                            ((cmd.rtype == RTYPE_P) && (cmd.length == 10'd0)));
        m_flr = cmd_put && !m_mal && func_in_rst &&
                ((cmd.rtype == RTYPE_P) || (cmd.rtype == RTYPE_NP));
        m_acc = cmd_put && !m_mal && !m_flr;
        m_poi = m_acc && cmd.ep;
        en_now  = {m_en_h[WIN_LEN-2:0], clk_enable_sys};
        p_now   = {m_p_h[WIN_LEN-2:0], m_acc && (cmd.rtype == RTYPE_P)};
        np_now  = {m_np_h[WIN_LEN-2:0], m_acc && (cmd.rtype == RTYPE_NP)};
        cpl_now = {m_cpl_h[WIN_LEN-2:0], m_acc && (cmd.rtype == RTYPE_CPL)};
        // eight highs, oldest first, then eight lows.
        m_match = (en_now == {{WIN_HALF{1'b1}}, {WIN_HALF{1'b0}}});
    end

    function automatic logic [CNT_W-1:0] sat_add(input logic [CNT_W-1:0] cnt,
                                                 input int unsigned inc);
        int unsigned total;
        total = cnt + inc;
        if (total > CNT_MAX) begin
            total = CNT_MAX;
        end
        return CNT_W'(total);
    endfunction

    always_ff @(posedge hqm_sif_core or negedge rst_n) begin
        if (!rst_n) begin
            m_en_h <= '1;
            m_p_h <= '0;
            m_np_h <= '0;
            m_cpl_h <= '0;
            {m_drop_s1, m_haz_s1, m_flr_s1, m_poi_s1, m_mal_s1} <= '0;
            {m_drop_s2, m_haz_s2} <= '0;
            {m_wp_s1, m_wnp_s1, m_wcpl_s1, m_wp_s2, m_wnp_s2, m_wcpl_s2} <= '0;
            {m_hz_p, m_hz_np, m_hz_cpl, m_drops, m_flr_cnt, m_poi_cnt, m_mal_cnt} <= '0;
        end else begin
            m_en_h <= en_now;
            m_p_h <= p_now;
            m_np_h <= np_now;
            m_cpl_h <= cpl_now;
            m_drop_s1 <= m_match;
            m_haz_s1 <= m_match && (|(p_now | np_now | cpl_now));
            m_wp_s1 <= $countones(p_now);
            m_wnp_s1 <= $countones(np_now);
            m_wcpl_s1 <= $countones(cpl_now);
            m_flr_s1 <= m_flr;
            m_poi_s1 <= m_poi;
            m_mal_s1 <= m_mal;
            m_drop_s2 <= m_drop_s1;
            m_haz_s2 <= m_haz_s1;
            m_wp_s2 <= m_wp_s1;
            m_wnp_s2 <= m_wnp_s1;
            m_wcpl_s2 <= m_wcpl_s1;
            if (stats_clr) begin
                {m_hz_p, m_hz_np, m_hz_cpl, m_drops, m_flr_cnt, m_poi_cnt, m_mal_cnt} <= '0;
            end else begin
                if (m_drop_s2) begin
                    m_hz_p <= sat_add(m_hz_p, m_wp_s2);
                    m_hz_np <= sat_add(m_hz_np, m_wnp_s2);
                    m_hz_cpl <= sat_add(m_hz_cpl, m_wcpl_s2);
                    m_drops <= sat_add(m_drops, 1);
                end
                m_flr_cnt <= sat_add(m_flr_cnt, m_flr_s1);
                m_poi_cnt <= sat_add(m_poi_cnt, m_poi_s1);
                m_mal_cnt <= sat_add(m_mal_cnt, m_mal_s1);
            end
        end
    end

    task automatic report_mismatch(input string name, input logic [CNT_W-1:0] exp_v,
                                   input logic [CNT_W-1:0] act_v);
        $display("[ERROR] %s expected 0x%0h actual 0x%0h at %0t", name, exp_v, act_v, $time);
        error_count++;
    endtask

    a_hazard: assert property (@(posedge hqm_sif_core) disable iff (!rst_n)
        gate_hazard == m_haz_s2)
        else report_mismatch("o_gate_hazard", CNT_W'($sampled(m_haz_s2)),
                             CNT_W'($sampled(gate_hazard)));
    a_hz_p: assert property (@(posedge hqm_sif_core) disable iff (!rst_n)
        stats.hazard_p == m_hz_p)
        else report_mismatch("o_stats.hazard_p", $sampled(m_hz_p), $sampled(stats.hazard_p));
    a_hz_np: assert property (@(posedge hqm_sif_core) disable iff (!rst_n)
        stats.hazard_np == m_hz_np)
        else report_mismatch("o_stats.hazard_np", $sampled(m_hz_np), $sampled(stats.hazard_np));
    a_hz_cpl: assert property (@(posedge hqm_sif_core) disable iff (!rst_n)
        stats.hazard_cpl == m_hz_cpl)
        else report_mismatch("o_stats.hazard_cpl", $sampled(m_hz_cpl),
                             $sampled(stats.hazard_cpl));
    a_drops: assert property (@(posedge hqm_sif_core) disable iff (!rst_n)
        stats.gate_drops == m_drops)
        else report_mismatch("o_stats.gate_drops", $sampled(m_drops), $sampled(stats.gate_drops));
    a_flr: assert property (@(posedge hqm_sif_core) disable iff (!rst_n)
        stats.drop_flr == m_flr_cnt)
        else report_mismatch("o_stats.drop_flr", $sampled(m_flr_cnt), $sampled(stats.drop_flr));
    a_poi: assert property (@(posedge hqm_sif_core) disable iff (!rst_n)
        stats.poisoned == m_poi_cnt)
        else report_mismatch("o_stats.poisoned", $sampled(m_poi_cnt), $sampled(stats.poisoned));
    a_mal: assert property (@(posedge hqm_sif_core) disable iff (!rst_n)
        stats.malform == m_mal_cnt)
        else report_mismatch("o_stats.malform", $sampled(m_mal_cnt), $sampled(stats.malform));

    task automatic check_value(input string name, input logic [CNT_W-1:0] exp_v,
                               input logic [CNT_W-1:0] act_v);
        if (exp_v !== act_v) begin
            report_mismatch(name, exp_v, act_v);
        end
    endtask

    task automatic check_stats_zero();
        check_value("o_stats.hazard_p", '0, stats.hazard_p);
        check_value("o_stats.hazard_np", '0, stats.hazard_np);
        check_value("o_stats.hazard_cpl", '0, stats.hazard_cpl);
        check_value("o_stats.gate_drops", '0, stats.gate_drops);
        check_value("o_stats.drop_flr", '0, stats.drop_flr);
        check_value("o_stats.poisoned", '0, stats.poisoned);
        check_value("o_stats.malform", '0, stats.malform);
    endtask

    // galois lfsr stepped once per bit taken.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic drive(input logic put, input sif_cmd_t c, input logic fir, input logic en,
                         input logic clr);
        @(negedge hqm_sif_core);
        cmd_put = put;
        cmd = c;
        func_in_rst = fir;
        clk_enable_sys = en;
        stats_clr = clr;
    endtask

    task automatic idle(input int n, input logic en);
        for (int i = 0; i < n; i++) begin
            drive(1'b0, '0, 1'b0, en, 1'b0);
        end
    endtask

    // slot 0 lies before the window, slots 1 to 16 inside, slot 17 after.
    task automatic gate_window(input logic [17:0] mask, input sif_cmd_t c, input logic fir,
                               input logic clr_after);
        for (int k = 0; k < 18; k++) begin
            drive(mask[k], c, fir, (k <= 8), 1'b0);
        end
        drive(1'b0, '0, 1'b0, 1'b0, clr_after);
        idle(3, 1'b0);
        idle(10, 1'b1);
    endtask

    task automatic finish_test(input string name);
        if (error_count == test_errors) begin
            pass_count++;
            $display("test %s passed", name);
        end else begin
            fail_count++;
            $display("test %s failed with %0d errors", name, error_count - test_errors);
        end
        test_errors = error_count;
    endtask

    initial begin
        #(WATCHDOG_CYC * 100);
        $display("watchdog expired before the tests completed");
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        logic [31:0] r;
        logic        put_bit;
        sif_cmd_t    c;
        lfsr_state = 32'hce73;
        error_count = 0;
        test_errors = 0;
        pass_count = 0;
        fail_count = 0;
        rst_n = 1'b0;
        cmd_put = 1'b0;
        cmd = '0;
        func_in_rst = 1'b0;
        clk_enable_sys = 1'b1;
        stats_clr = 1'b0;
        repeat (3) @(negedge hqm_sif_core);
        rst_n = 1'b1;

        check_value("o_gate_hazard", '0, CNT_W'(gate_hazard));
        check_stats_zero();
        finish_test("reset");

        drive(1'b0, '0, 1'b0, 1'b1, 1'b1);
        for (int i = 0; i < 60; i++) begin
            rand_bits(2, r);
            c.rtype = sif_rtype_e'(r[1:0]);
            rand_bits(1, r);
            c.ep = r[0];
            rand_bits(2, r);
            if (r[1:0] == 2'd0) begin
                c.length = '0;
            end else begin
                rand_bits(10, r);
                c.length = r[9:0];
            end
            rand_bits(1, r);
            put_bit = r[0];
            rand_bits(1, r);
            drive(put_bit, c, r[0], 1'b1, 1'b0);
        end
        idle(4, 1'b1);
        finish_test("random classification");

        drive(1'b0, '0, 1'b0, 1'b1, 1'b1);
        idle(8, 1'b0);
        idle(8, 1'b1);
        idle(3, 1'b0);
        idle(1, 1'b1);
        idle(12, 1'b0);
        idle(5, 1'b1);
        idle(10, 1'b0);
        idle(10, 1'b1);
        check_value("o_stats.gate_drops", CNT_W'(1), stats.gate_drops);
        check_value("o_stats.hazard_p", '0, stats.hazard_p);
        finish_test("gate drop pattern");

        drive(1'b0, '0, 1'b0, 1'b1, 1'b1);
        idle(9, 1'b1);
        c = '{rtype: RTYPE_P, ep: 1'b0, length: 10'd5};
        gate_window(18'h3_0003, c, 1'b0, 1'b0);
        check_value("o_stats.hazard_p", CNT_W'(2), stats.hazard_p);
        c = '{rtype: RTYPE_NP, ep: 1'b1, length: 10'd1};
        gate_window(18'h1_fffe, c, 1'b1, 1'b0);
        c = '{rtype: RTYPE_CPL, ep: 1'b0, length: 10'd2};
        gate_window(18'h0_5554, c, 1'b1, 1'b0);
        c = '{rtype: RTYPE_RSVD, ep: 1'b0, length: 10'd4};
        gate_window(18'h1_fffe, c, 1'b0, 1'b0);
        c = '{rtype: RTYPE_NP, ep: 1'b0, length: 10'd3};
        gate_window(18'h2_0001, c, 1'b0, 1'b0);
        finish_test("hazard window slots");

        c = '{rtype: RTYPE_NP, ep: 1'b1, length: 10'd3};
        gate_window(18'h3_fffe, c, 1'b0, 1'b1);
        idle(3, 1'b1);
        check_stats_zero();
        drive(1'b0, '0, 1'b0, 1'b1, 1'b1);
        idle(3, 1'b1);
        finish_test("statistics clear");

        for (int t = 0; t < 3; t++) begin
            c = '{rtype: sif_rtype_e'(t), ep: 1'b0, length: 10'd8};
            for (int w = 0; w < 6; w++) begin
                gate_window(18'h1_fffe, c, 1'b0, 1'b0);
            end
        end
        check_value("o_stats.hazard_p", CNT_W'(CNT_MAX), stats.hazard_p);
        check_value("o_stats.hazard_np", CNT_W'(CNT_MAX), stats.hazard_np);
        check_value("o_stats.hazard_cpl", CNT_W'(CNT_MAX), stats.hazard_cpl);
        finish_test("counter saturation");

        $display("tests passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/sif_monitor_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module sif_monitor_top
    import sif_mon_pkg::*;
#(
    parameter int unsigned CNT_WIDTH = CNT_W
) (
    input  wire logic     hqm_sif_core,
    input  wire logic     i_rst_n,
    input  wire logic     i_cmd_put,
    input  wire sif_cmd_t i_cmd,
    input  wire logic     i_func_in_rst,
    input  wire logic     i_clk_enable_sys,
    input  wire logic     i_stats_clr,
    output logic          o_gate_hazard,
    output sif_stats_t    o_stats
);

    logic                 cls_v;
    sif_cls_t             cls;
    logic                 drop_v;
    logic [WIN_CNT_W-1:0] win_p;
    logic [WIN_CNT_W-1:0] win_np;
    logic [WIN_CNT_W-1:0] win_cpl;
    logic [CNT_WIDTH-1:0] hazard_p_cnt;
    logic [CNT_WIDTH-1:0] hazard_np_cnt;
    logic [CNT_WIDTH-1:0] hazard_cpl_cnt;
    logic [CNT_WIDTH-1:0] gate_drops_cnt;
    logic [CNT_WIDTH-1:0] drop_flr_cnt;
    logic [CNT_WIDTH-1:0] poisoned_cnt;
    logic [CNT_WIDTH-1:0] malform_cnt;

    sif_cmd_decode u_cmd_decode (
        .hqm_sif_core  (hqm_sif_core),
        .i_rst_n       (i_rst_n),
        .i_cmd_put     (i_cmd_put),
        .i_cmd         (i_cmd),
        .i_func_in_rst (i_func_in_rst),
        .o_cls_v       (cls_v),
        .o_cls         (cls)
    );

    sif_clkgate_window u_clkgate_window (
        .hqm_sif_core     (hqm_sif_core),
        .i_rst_n          (i_rst_n),
        .i_clk_enable_sys (i_clk_enable_sys),
        .i_cls_v          (cls_v),
        .i_cls            (cls),
        .o_drop_v         (drop_v),
        .o_win_p          (win_p),
        .o_win_np         (win_np),
        .o_win_cpl        (win_cpl),
        .o_gate_hazard    (o_gate_hazard)
    );

    // commands caught inside a gate drop window, per request type.
    sif_event_counter #(.WIDTH(CNT_WIDTH)) u_cnt_hazard_p (
        .hqm_sif_core (hqm_sif_core), .i_rst_n (i_rst_n), .i_clr (i_stats_clr),
        .i_inc_v (drop_v), .i_inc (win_p), .o_count (hazard_p_cnt)
    );

    sif_event_counter #(.WIDTH(CNT_WIDTH)) u_cnt_hazard_np (
        .hqm_sif_core (hqm_sif_core), .i_rst_n (i_rst_n), .i_clr (i_stats_clr),
        .i_inc_v (drop_v), .i_inc (win_np), .o_count (hazard_np_cnt)
    );

    sif_event_counter #(.WIDTH(CNT_WIDTH)) u_cnt_hazard_cpl (
        .hqm_sif_core (hqm_sif_core), .i_rst_n (i_rst_n), .i_clr (i_stats_clr),
        .i_inc_v (drop_v), .i_inc (win_cpl), .o_count (hazard_cpl_cnt)
    );

    sif_event_counter #(.WIDTH(CNT_WIDTH)) u_cnt_gate_drops (
        .hqm_sif_core (hqm_sif_core), .i_rst_n (i_rst_n), .i_clr (i_stats_clr),
        .i_inc_v (drop_v), .i_inc (WIN_CNT_W'(1)), .o_count (gate_drops_cnt)
    );

    // decoder error classes, one per strobe.
    sif_event_counter #(.WIDTH(CNT_WIDTH)) u_cnt_drop_flr (
        .hqm_sif_core (hqm_sif_core), .i_rst_n (i_rst_n), .i_clr (i_stats_clr),
        .i_inc_v (cls_v & cls.drop_flr), .i_inc (WIN_CNT_W'(1)), .o_count (drop_flr_cnt)
    );

    sif_event_counter #(.WIDTH(CNT_WIDTH)) u_cnt_poisoned (
        .hqm_sif_core (hqm_sif_core), .i_rst_n (i_rst_n), .i_clr (i_stats_clr),
        .i_inc_v (cls_v & cls.poisoned), .i_inc (WIN_CNT_W'(1)), .o_count (poisoned_cnt)
    );

    sif_event_counter #(.WIDTH(CNT_WIDTH)) u_cnt_malform (
        .hqm_sif_core (hqm_sif_core), .i_rst_n (i_rst_n), .i_clr (i_stats_clr),
        .i_inc_v (cls_v & cls.malform), .i_inc (WIN_CNT_W'(1)), .o_count (malform_cnt)
    );

    // narrower builds are zero extended into the stats fields.
    assign o_stats.hazard_p   = CNT_W'(hazard_p_cnt);
    assign o_stats.hazard_np  = CNT_W'(hazard_np_cnt);
    assign o_stats.hazard_cpl = CNT_W'(hazard_cpl_cnt);
    assign o_stats.gate_drops = CNT_W'(gate_drops_cnt);
    assign o_stats.drop_flr   = CNT_W'(drop_flr_cnt);
    assign o_stats.poisoned   = CNT_W'(poisoned_cnt);
    assign o_stats.malform    = CNT_W'(malform_cnt);

endmodule

`default_nettype wire

// ==== design/sif_event_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module sif_event_counter
    import sif_mon_pkg::*;
#(
    parameter int unsigned WIDTH = CNT_W
) (
    input  wire logic                 hqm_sif_core,
    input  wire logic                 i_rst_n,
    input  wire logic                 i_clr,
    input  wire logic                 i_inc_v,
    input  wire logic [WIN_CNT_W-1:0] i_inc,
    output logic [WIDTH-1:0]          o_count
);

    // wide enough for all-ones plus the largest increment.
    logic [WIDTH+WIN_CNT_W-1:0] sum;
    logic                       ovf;
    logic [WIDTH-1:0]           count_nxt;

    always_comb begin
        sum = (WIDTH + WIN_CNT_W)'(o_count) + (WIDTH + WIN_CNT_W)'(i_inc);
        ovf = |sum[WIDTH+WIN_CNT_W-1:WIDTH];
        if (ovf) begin
            count_nxt = '1;
        end else begin
            count_nxt = sum[WIDTH-1:0];
        end
    end

    // clear takes priority over a same-cycle increment.
    always_ff @(posedge hqm_sif_core or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_count <= '0;
        end else if (i_clr) begin
            o_count <= '0;
        end else if (i_inc_v) begin
            o_count <= count_nxt;
        end
    end

endmodule

`default_nettype wire

// ==== design/sif_clkgate_window.sv ====
`timescale 1ns/1ps
`default_nettype none

module sif_clkgate_window
    import sif_mon_pkg::*;
(
    input  wire logic        hqm_sif_core,
    input  wire logic        i_rst_n,
    input  wire logic        i_clk_enable_sys,
    input  wire logic        i_cls_v,
    input  wire sif_cls_t    i_cls,
    output logic             o_drop_v,
    output logic [WIN_CNT_W-1:0] o_win_p,
    output logic [WIN_CNT_W-1:0] o_win_np,
    output logic [WIN_CNT_W-1:0] o_win_cpl,
    output logic             o_gate_hazard
);

    logic                 en_d;
    logic [WIN_LEN-1:0]   en_hist_q;
    logic [WIN_LEN-1:0]   p_hist_q;
    logic [WIN_LEN-1:0]   np_hist_q;
    logic [WIN_LEN-1:0]   cpl_hist_q;
    logic [WIN_LEN-1:0]   en_hist_nxt;
    logic [WIN_LEN-1:0]   p_hist_nxt;
    logic [WIN_LEN-1:0]   np_hist_nxt;
    logic [WIN_LEN-1:0]   cpl_hist_nxt;
    logic                 drop_match;
    logic                 any_cmd;
    logic [WIN_CNT_W-1:0] cnt_p;
    logic [WIN_CNT_W-1:0] cnt_np;
    logic [WIN_CNT_W-1:0] cnt_cpl;

    function automatic logic [WIN_CNT_W-1:0] popcount(input logic [WIN_LEN-1:0] vec);
        logic [WIN_CNT_W-1:0] cnt;
        cnt = '0;
        for (int i = 0; i < WIN_LEN; i++) begin
            cnt = cnt + WIN_CNT_W'(vec[i]);
        end
        return cnt;
    endfunction

    // en_d lines the enable up with the decoder output, so slot 0 of
    // every history below refers to the same input cycle.
    always_comb begin
        en_hist_nxt  = {en_hist_q[WIN_LEN-2:0], en_d};
        p_hist_nxt   = {p_hist_q[WIN_LEN-2:0], i_cls_v & i_cls.is_p};
        np_hist_nxt  = {np_hist_q[WIN_LEN-2:0], i_cls_v & i_cls.is_np};
        cpl_hist_nxt = {cpl_hist_q[WIN_LEN-2:0], i_cls_v & i_cls.is_cpl};
    end

    // matching on the next history saves a cycle of latency.
    always_comb begin
        drop_match = (en_hist_nxt == GATE_PAT);
        cnt_p      = popcount(p_hist_nxt);
        cnt_np     = popcount(np_hist_nxt);
        cnt_cpl    = popcount(cpl_hist_nxt);
        any_cmd    = |(p_hist_nxt | np_hist_nxt | cpl_hist_nxt);
    end

    always_ff @(posedge hqm_sif_core or negedge i_rst_n) begin
        if (!i_rst_n) begin
            en_d       <= 1'b1;
            en_hist_q  <= '1;
            p_hist_q   <= '0;
            np_hist_q  <= '0;
            cpl_hist_q <= '0;
        end else begin
            en_d       <= i_clk_enable_sys;
            en_hist_q  <= en_hist_nxt;
            p_hist_q   <= p_hist_nxt;
            np_hist_q  <= np_hist_nxt;
            cpl_hist_q <= cpl_hist_nxt;
        end
    end

    always_ff @(posedge hqm_sif_core or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_drop_v      <= 1'b0;
            o_gate_hazard <= 1'b0;
            o_win_p       <= '0;
            o_win_np      <= '0;
            o_win_cpl     <= '0;
        end else begin
            o_drop_v      <= drop_match;
            o_gate_hazard <= drop_match & any_cmd;
            o_win_p       <= drop_match ? cnt_p : '0;
            o_win_np      <= drop_match ? cnt_np : '0;
            o_win_cpl     <= drop_match ? cnt_cpl : '0;
        end
    end

endmodule

`default_nettype wire

// ==== design/sif_cmd_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module sif_cmd_decode
    import sif_mon_pkg::*;
(
    input  wire logic     hqm_sif_core,
    input  wire logic     i_rst_n,
    input  wire logic     i_cmd_put,
    input  wire sif_cmd_t i_cmd,
    input  wire logic     i_func_in_rst,
    output logic          o_cls_v,
    output sif_cls_t      o_cls
);

    logic     malform;
    logic     drop_flr;
    logic     accepted;
    logic     is_req;
    sif_cls_t cls_d;

    // a posted write must carry data, and type 3 is reserved.
    always_comb begin
        malform = (i_cmd.rtype == RTYPE_RSVD) ||
                  ((i_cmd.rtype == RTYPE_P) && (i_cmd.length == '0));
    end

    // requests to a function in reset are dropped, completions always pass.
    always_comb begin
        is_req   = (i_cmd.rtype == RTYPE_P) || (i_cmd.rtype == RTYPE_NP);
        drop_flr = !malform && i_func_in_rst && is_req;
        accepted = !malform && !drop_flr;
    end

    always_comb begin
        cls_d          = '0;
        cls_d.is_p     = accepted && (i_cmd.rtype == RTYPE_P);
        cls_d.is_np    = accepted && (i_cmd.rtype == RTYPE_NP);
        cls_d.is_cpl   = accepted && (i_cmd.rtype == RTYPE_CPL);
        cls_d.drop_flr = drop_flr;
        cls_d.poisoned = accepted && i_cmd.ep;
        cls_d.malform  = malform;
    end

    always_ff @(posedge hqm_sif_core or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_cls_v <= 1'b0;
        end else begin
            o_cls_v <= i_cmd_put;
        end
    end

    // class flags are only looked at together with o_cls_v.
    always_ff @(posedge hqm_sif_core) begin
        if (i_cmd_put) begin
            o_cls <= cls_d;
        end
    end

endmodule

`default_nettype wire

// ==== design/sif_mon_pkg.sv ====
`default_nettype none

package sif_mon_pkg;

    // cycles on each side of a clock gate drop.
    localparam int unsigned WIN_HALF = 8;
    localparam int unsigned WIN_LEN = 2 * WIN_HALF;

    // a window count spans 0 to WIN_LEN.
    localparam int unsigned WIN_CNT_W = $clog2(WIN_LEN + 1);

    localparam int unsigned CNT_W = 16;

    // enable history seen at a gate drop, oldest slot in the msb.
    localparam logic [WIN_LEN-1:0] GATE_PAT = {{WIN_HALF{1'b1}}, {WIN_HALF{1'b0}}};

    typedef enum logic [1:0] {
        RTYPE_P    = 2'd0,
        RTYPE_NP   = 2'd1,
        RTYPE_CPL  = 2'd2,
        RTYPE_RSVD = 2'd3
    } sif_rtype_e;

    typedef struct packed {
        sif_rtype_e  rtype;
        logic        ep;
        // data length in dwords.
        logic [9:0]  length;
    } sif_cmd_t;

    typedef struct packed {
        logic is_p;
        logic is_np;
        logic is_cpl;
        logic drop_flr;
        logic poisoned;
        logic malform;
    } sif_cls_t;

    typedef struct packed {
        logic [CNT_W-1:0] hazard_p;
        logic [CNT_W-1:0] hazard_np;
        logic [CNT_W-1:0] hazard_cpl;
        logic [CNT_W-1:0] gate_drops;
        logic [CNT_W-1:0] drop_flr;
        logic [CNT_W-1:0] poisoned;
        logic [CNT_W-1:0] malform;
    } sif_stats_t;

endpackage

`default_nettype wire
